// ==== files.f ====
+incdir+hdl
hdl/board_pkg.sv
hdl/sync_and_debounce.sv
hdl/strobe_gen.sv
hdl/shift_pattern.sv
hdl/moore_fsm.sv
hdl/mealy_fsm.sv
hdl/seven_segment.sv
hdl/top.sv
dv/tb_top.sv

// ==== Bender.yml ====
package:
  name: board_demo

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/board_pkg.sv
      - hdl/sync_and_debounce.sv
      - hdl/strobe_gen.sv
      - hdl/shift_pattern.sv
      - hdl/moore_fsm.sv
      - hdl/mealy_fsm.sv
      - hdl/seven_segment.sv
      - hdl/top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/tb_top.sv

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module tb_top;

    import board_pkg::*;

    localparam int STROBE_CYC = 256;
    localparam int FIXED_LEN  = 16;
    localparam int RAND_LEN   = 20;
    localparam int N_STROBES  = FIXED_LEN + RAND_LEN + 3;
    localparam int TIMEOUT_NS = (N_STROBES + 4) * STROBE_CYC * 20;
    localparam int SETTLE_CYC = 16;
    // The debounce delay is at least 2^DB_W cycles.
    localparam int EARLY_CYC  = 8;

    logic                     clk = 1'b0;
    logic                     i_rst;
    logic [`BOARD_KEY_W-1:0]  i_key;
    logic [`BOARD_SW_W-1:0]   i_sw;
    logic [`BOARD_LED_W-1:0]  o_led;
    seg_out_t                 o_abcdefgh;
    logic [`BOARD_DIGITS-1:0] o_digit;
    logic                     o_buzzer;

    // Intended active-high input levels and the reference model state.
    logic          key1_level;
    logic          key0_level;
    logic          key0_prev;
    logic [7:0]    sw_level;
    int            cyc;
    int            last_change_cyc;
    logic          strobe_m;
    led_pattern_t  pattern_m;
    count16_t      strobe_cnt_m;
    count8_t       moore_cnt_m;
    count8_t       mealy_cnt_m;
    logic [1:0]    det_hist;
    logic          moore_pending;
    display_word_t disp_m;
    logic [7:0]    prev_digit;
    int            hold_cnt;
    logic [2:0]    sel_idx;
    logic [6:0]    exp_seg;
    integer        seed = 60511;
    int            led_errors = 0;
    int            disp_errors = 0;
    int            det_errors = 0;
    int            io_errors = 0;

    top #(.SHIFT_W(8), .SCAN_W(2), .DB_W(3)) UUT (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_key      (i_key),
        .i_sw       (i_sw),
        .o_led      (o_led),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit),
        .o_buzzer   (o_buzzer)
    );

    always #10 clk = ~clk;

    // Usual hex forms with segment a in the top bit.
    function automatic logic [6:0] hex_segments(input logic [3:0] n);
        logic [6:0] table_seg [16];
        table_seg = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
                      7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};
        return table_seg[n];
    endfunction

    function automatic logic [2:0] sel_index(input logic [7:0] sel_n);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (!sel_n[i]) idx = i[2:0];
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model.
    //////////////////////////////////////////////////////////////////////

    // Shift strobe is high in the cycle after every 256th edge.
    assign strobe_m = (cyc != 0) && (cyc % STROBE_CYC == 0);
    assign disp_m   = {strobe_cnt_m, moore_cnt_m, mealy_cnt_m};
    assign sel_idx  = sel_index(o_digit);
    assign exp_seg  = hex_segments(disp_m[sel_idx*4 +: 4]);

    always @(posedge clk) begin
        if (i_rst) begin
            cyc           <= 0;
            pattern_m     <= '0;
            strobe_cnt_m  <= '0;
            moore_cnt_m   <= '0;
            mealy_cnt_m   <= '0;
            det_hist      <= '0;
            moore_pending <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (strobe_m) begin
                pattern_m    <= {pattern_m[10:0], key1_level};
                strobe_cnt_m <= strobe_cnt_m + 1'b1;
                // Detectors see the three newest bits one strobe late.
                det_hist      <= {det_hist[0], pattern_m[0]};
                moore_pending <= ({det_hist, pattern_m[0]} == 3'b101);
                if ({det_hist, pattern_m[0]} == 3'b101) mealy_cnt_m <= mealy_cnt_m + 1'b1;
                if (moore_pending) moore_cnt_m <= moore_cnt_m + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        prev_digit <= o_digit;
        if (i_rst || (o_digit != prev_digit)) begin
            hold_cnt <= 0;
        end else begin
            hold_cnt <= hold_cnt + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////////////////////////

    led_check: assert property (@(posedge clk) disable iff (i_rst) ~o_led == pattern_m)
    else begin
        led_errors++;
        $display("** Error at %0t: o_led expected %h, got %h",
                 $time, ~$sampled(pattern_m), $sampled(o_led));
    end

    onehot_check: assert property (@(posedge clk) disable iff (i_rst) $onehot(~o_digit))
    else begin
        disp_errors++;
        $display("** Error at %0t: o_digit expected one low bit, got %b",
                 $time, $sampled(o_digit));
    end

    step_check: assert property (@(posedge clk) disable iff (i_rst)
        (o_digit == prev_digit) || (o_digit == {prev_digit[6:0], prev_digit[7]}))
    else begin
        disp_errors++;
        $display("** Error at %0t: o_digit expected %b or its rotation, got %b",
                 $time, $sampled(prev_digit), $sampled(o_digit));
    end

    scan_check: assert property (@(posedge clk) disable iff (i_rst) hold_cnt < 8)
    else begin
        disp_errors++;
        $display("Digit scan stopped advancing at %0t", $time);
    end

    // Held off just after a shift strobe while the display catches up.
    seg_check: assert property (@(posedge clk) disable iff (i_rst)
        (cyc % STROBE_CYC < 4) || (~o_abcdefgh.segments == exp_seg))
    else begin
        disp_errors++;
        $display("** Error at %0t: o_abcdefgh.segments digit %0d expected %b, got %b",
                 $time, $sampled(sel_idx), ~$sampled(exp_seg), $sampled(o_abcdefgh.segments));
    end

    mealy_check: assert property (@(posedge clk) disable iff (i_rst)
        UUT.disp_word.mealy_count == mealy_cnt_m)
    else begin
        det_errors++;
        $display("** Error at %0t: mealy_count expected %0d, got %0d",
                 $time, $sampled(mealy_cnt_m), $sampled(UUT.disp_word.mealy_count));
    end

    moore_check: assert property (@(posedge clk) disable iff (i_rst)
        UUT.disp_word.moore_count == moore_cnt_m)
    else begin
        det_errors++;
        $display("** Error at %0t: moore_count expected %0d, got %0d",
                 $time, $sampled(moore_cnt_m), $sampled(UUT.disp_word.moore_count));
    end

    dot_check: assert property (@(posedge clk) disable iff (i_rst)
        (cyc - last_change_cyc < SETTLE_CYC) || (~o_abcdefgh.dot == sw_level[sel_idx]))
    else begin
        io_errors++;
        $display("** Error at %0t: o_abcdefgh.dot digit %0d expected %b, got %b",
                 $time, $sampled(sel_idx), ~$sampled(sw_level[sel_idx]), $sampled(o_abcdefgh.dot));
    end

    buzzer_check: assert property (@(posedge clk) disable iff (i_rst)
        (cyc - last_change_cyc < SETTLE_CYC) || (~o_buzzer == key0_level))
    else begin
        io_errors++;
        $display("** Error at %0t: o_buzzer expected %b, got %b",
                 $time, ~$sampled(key0_level), $sampled(o_buzzer));
    end

    // Key 0 must not reach the buzzer before the debounce delay.
    buzzer_delay_check: assert property (@(posedge clk) disable iff (i_rst)
        (cyc - last_change_cyc >= EARLY_CYC) || (~o_buzzer == key0_prev))
    else begin
        io_errors++;
        $display("** Error at %0t: o_buzzer expected %b before the debounce delay, got %b",
                 $time, ~$sampled(key0_prev), $sampled(o_buzzer));
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic change_aux();
        key0_prev       = key0_level;
        key0_level      = ~key0_level;
        sw_level        = 8'($random(seed));
        i_key[0]        = ~key0_level;
        i_sw            = ~sw_level;
        last_change_cyc = cyc;
    endtask

    // Called midway between strobes, so the key is settled well before the next one.
    task automatic drive_key1(input logic b);
        key1_level = b;
        i_key[1]   = ~b;
        wait_cycles(STROBE_CYC);
    endtask

    initial begin
        logic [FIXED_LEN-1:0] fixed_seq;
        int                   total;
        fixed_seq       = 16'b1010_1101_1010_0101;
        i_rst           = 1'b1;
        i_key           = '1;
        i_sw            = '1;
        key1_level      = 1'b0;
        key0_level      = 1'b0;
        key0_prev       = 1'b0;
        sw_level        = '0;
        last_change_cyc = -SETTLE_CYC;
        wait_cycles(2);
        i_rst = 1'b0;
        wait_cycles(STROBE_CYC / 2);
        for (int i = FIXED_LEN - 1; i >= 0; i--) begin
            if (i % 4 == 0) change_aux();
            drive_key1(fixed_seq[i]);
        end
        change_aux();
        for (int i = 0; i < RAND_LEN; i++) begin
            if (i % 5 == 4) change_aux();
            drive_key1(1'($random(seed)));
        end
        // Let the last bits reach both detectors.
        wait_cycles(3 * STROBE_CYC);
        total = led_errors + disp_errors + det_errors + io_errors;
        $display("Errors: led %0d, display %0d, detector %0d, dot/buzzer %0d, total %0d",
                 led_errors, disp_errors, det_errors, io_errors, total);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the stimulus did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/top.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module top #(
    parameter int SHIFT_W = `SHIFT_STROBE_W,
    parameter int SCAN_W  = `SCAN_STROBE_W,
    parameter int DB_W    = `DEBOUNCE_W
) (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic [`BOARD_KEY_W-1:0]   i_key,
    input  logic [`BOARD_SW_W-1:0]    i_sw,
    output logic [`BOARD_LED_W-1:0]   o_led,
    output board_pkg::seg_out_t       o_abcdefgh,
    output logic [`BOARD_DIGITS-1:0]  o_digit,
    output logic                      o_buzzer
);

    import board_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Input conditioning.
    //////////////////////////////////////////////////////////////////////

    logic [`BOARD_KEY_W-1:0] key_db;
    logic [`BOARD_SW_W-1:0]  sw_db;

    sync_and_debounce #(.W(`BOARD_KEY_W), .DB_W(DB_W)) u_key_db (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_raw   (i_key),
        .o_level (key_db)
    );

    sync_and_debounce #(.W(`BOARD_SW_W), .DB_W(DB_W)) u_sw_db (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_raw   (i_sw),
        .o_level (sw_db)
    );

    //////////////////////////////////////////////////////////////////////
    // Strobes.
    //////////////////////////////////////////////////////////////////////

    logic shift_strobe;
    logic scan_strobe;

    strobe_gen #(.W(SHIFT_W)) u_shift_strobe (
        .clk      (clk),
        .i_rst    (i_rst),
        .o_strobe (shift_strobe)
    );

    strobe_gen #(.W(SCAN_W)) u_scan_strobe (
        .clk      (clk),
        .i_rst    (i_rst),
        .o_strobe (scan_strobe)
    );

    //////////////////////////////////////////////////////////////////////
    // Pattern and detectors.
    //////////////////////////////////////////////////////////////////////

    led_pattern_t  pattern;
    display_word_t disp_word;

    shift_pattern u_shift_pattern (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_en           (shift_strobe),
        .i_bit          (key_db[1]),
        .o_pattern      (pattern),
        .o_strobe_count (disp_word.strobe_count)
    );

    // Both see the bit shifted in on the previous strobe.
    moore_fsm u_moore_fsm (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_en    (shift_strobe),
        .i_a     (pattern[0]),
        .o_y     (),
        .o_count (disp_word.moore_count)
    );

    mealy_fsm u_mealy_fsm (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_en    (shift_strobe),
        .i_a     (pattern[0]),
        .o_y     (),
        .o_count (disp_word.mealy_count)
    );

    //////////////////////////////////////////////////////////////////////
    // Display and board outputs.
    //////////////////////////////////////////////////////////////////////

    seg_out_t                 seg;
    logic [`BOARD_DIGITS-1:0] digit_sel;

    seven_segment u_seven_segment (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_en     (scan_strobe),
        .i_num    (disp_word),
        .i_dots   (sw_db),
        .o_seg    (seg),
        .o_select (digit_sel)
    );

    // The board drives everything active low.
    assign o_led      = ~pattern;
    assign o_abcdefgh = seg_out_t'(~seg);
    assign o_digit    = ~digit_sel;
    assign o_buzzer   = ~key_db[0];

endmodule

// ==== hdl/seven_segment.sv ====
`timescale 1ns/1ps

module seven_segment (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  board_pkg::display_word_t i_num,
    input  logic [7:0]               i_dots,
    output board_pkg::seg_out_t      o_seg,
    output logic [7:0]               o_select
);

    import board_pkg::*;

    digit_idx_t digit_idx;
    nibble_t    cur_nibble;
    logic [6:0] cur_segments;

    //////////////////////////////////////////////////////////////////////
    // Digit scan.
    //////////////////////////////////////////////////////////////////////

    // Three bits, so the index wraps after digit 7 by itself.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            digit_idx <= '0;
        end else if (i_en) begin
            digit_idx <= digit_idx + 1'b1;
        end
    end

    // Digit 0 shows the least significant nibble.
    assign cur_nibble = i_num[digit_idx*4 +: 4];

    //////////////////////////////////////////////////////////////////////
    // Hex decode, segments abcdefg with a at the top.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cur_nibble)
            4'h0:    cur_segments = 7'b1111110;
            4'h1:    cur_segments = 7'b0110000;
            4'h2:    cur_segments = 7'b1101101;
            4'h3:    cur_segments = 7'b1111001;
            4'h4:    cur_segments = 7'b0110011;
            4'h5:    cur_segments = 7'b1011011;
            4'h6:    cur_segments = 7'b1011111;
            4'h7:    cur_segments = 7'b1110000;
            4'h8:    cur_segments = 7'b1111111;
            4'h9:    cur_segments = 7'b1111011;
            4'ha:    cur_segments = 7'b1110111;
            4'hb:    cur_segments = 7'b0011111;
            4'hc:    cur_segments = 7'b1001110;
            4'hd:    cur_segments = 7'b0111101;
            4'he:    cur_segments = 7'b1001111;
            default: cur_segments = 7'b1000111;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        o_seg.segments <= cur_segments;
        o_seg.dot      <= i_dots[digit_idx];
    end

    // One-hot select, digit 0 lit out of reset.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_select <= 8'b0000_0001;
        end else begin
            o_select <= 8'b0000_0001 << digit_idx;
        end
    end

endmodule

// ==== hdl/mealy_fsm.sv ====
`timescale 1ns/1ps

module mealy_fsm (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_en,
    input  logic               i_a,
    output logic               o_y,
    output board_pkg::count8_t o_count
);

    import board_pkg::*;

    mealy_state_t state;
    mealy_state_t next_state;
    count8_t      count_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= MEALY_IDLE;
        end else if (i_en) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MEALY_IDLE:   next_state = i_a ? MEALY_GOT_1 : MEALY_IDLE;
            MEALY_GOT_1:  next_state = i_a ? MEALY_GOT_1 : MEALY_GOT_10;
            MEALY_GOT_10: next_state = i_a ? MEALY_GOT_1 : MEALY_IDLE;
            default:      next_state = MEALY_IDLE;
        endcase
    end

    // Detection depends on the incoming bit, qualified by the strobe.
    assign o_y = i_en && (state == MEALY_GOT_10) && i_a;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            count_q <= '0;
        end else if (o_y) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign o_count = count_q;

endmodule

// ==== hdl/moore_fsm.sv ====
`timescale 1ns/1ps

module moore_fsm (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_en,
    input  logic               i_a,
    output logic               o_y,
    output board_pkg::count8_t o_count
);

    import board_pkg::*;

    moore_state_t state;
    moore_state_t next_state;
    count8_t      count_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= MOORE_IDLE;
        end else if (i_en) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MOORE_IDLE:     next_state = i_a ? MOORE_GOT_1 : MOORE_IDLE;
            MOORE_GOT_1:    next_state = i_a ? MOORE_GOT_1 : MOORE_GOT_10;
            MOORE_GOT_10:   next_state = i_a ? MOORE_DETECTED : MOORE_IDLE;
            // The final 1 also starts the next match.
            MOORE_DETECTED: next_state = i_a ? MOORE_GOT_1 : MOORE_GOT_10;
            default:        next_state = MOORE_IDLE;
        endcase
    end

    // Output is a function of state alone.
    assign o_y = (state == MOORE_DETECTED);

    // Counted on the strobe after the detection.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            count_q <= '0;
        end else if (i_en && o_y) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign o_count = count_q;

endmodule

// ==== hdl/shift_pattern.sv ====
`timescale 1ns/1ps

module shift_pattern (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_en,
    input  logic                    i_bit,
    output board_pkg::led_pattern_t o_pattern,
    output board_pkg::count16_t     o_strobe_count
);

    import board_pkg::*;

    led_pattern_t pattern_q;
    count16_t     strobe_cnt_q;

    // Newest bit enters at the bottom, oldest falls off the top.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pattern_q <= '0;
        end else if (i_en) begin
            pattern_q <= {pattern_q[$bits(led_pattern_t)-2:0], i_bit};
        end
    end

    // Activity figure, wraps silently.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            strobe_cnt_q <= '0;
        end else if (i_en) begin
            strobe_cnt_q <= strobe_cnt_q + 1'b1;
        end
    end

    assign o_pattern      = pattern_q;
    assign o_strobe_count = strobe_cnt_q;

endmodule

// ==== hdl/strobe_gen.sv ====
`timescale 1ns/1ps

module strobe_gen #(
    parameter int W = 10
) (
    input  logic clk,
    input  logic i_rst,
    output logic o_strobe
);

    logic [W-1:0] cnt;

    // Pulse on the cycle after the counter reaches all ones.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            cnt      <= '0;
            o_strobe <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;
            o_strobe <= (cnt == '1);
        end
    end

endmodule

// ==== hdl/sync_and_debounce.sv ====
`timescale 1ns/1ps

module sync_and_debounce #(
    parameter int W    = 1,
    parameter int DB_W = 16
) (
    input  logic         clk,
    input  logic         i_rst,
    input  logic [W-1:0] i_raw,
    output logic [W-1:0] o_level
);

    logic [W-1:0]    meta_q;
    logic [W-1:0]    sync_q;
    logic [DB_W-1:0] stable_cnt;

    // Board inputs are active low, so invert on the way in.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= ~i_raw;
            sync_q <= meta_q;
        end
    end

    // One counter covers the whole bus.
    // It only runs while the synchronized value disagrees with the output.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            stable_cnt <= '0;
            o_level    <= '0;
        end else if (sync_q == o_level) begin
            stable_cnt <= '0;
        end else if (stable_cnt == '1) begin
            // Held long enough, take it.
            stable_cnt <= '0;
            o_level    <= sync_q;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/board_pkg.sv ====
`include "board_defines.svh"

package board_pkg;

    typedef logic [`BOARD_LED_W-1:0] led_pattern_t;
    typedef logic [15:0]             count16_t;
    typedef logic [7:0]              count8_t;
    typedef logic [3:0]              nibble_t;
    typedef logic [2:0]              digit_idx_t;

    // Overlapping 1-0-1 detector states.
    typedef enum logic [1:0] {
        MOORE_IDLE,
        MOORE_GOT_1,
        MOORE_GOT_10,
        MOORE_DETECTED
    } moore_state_t;

    typedef enum logic [1:0] {
        MEALY_IDLE,
        MEALY_GOT_1,
        MEALY_GOT_10
    } mealy_state_t;

    // Upper half, third byte, low byte.
    typedef struct packed {
        count16_t strobe_count;
        count8_t  moore_count;
        count8_t  mealy_count;
    } display_word_t;

    // Segment a sits at the top, the dot at the bottom.
    typedef struct packed {
        logic [6:0] segments;
        logic       dot;
    } seg_out_t;

endpackage

// ==== hdl/board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Trainer board I/O sizes.
//////////////////////////////////////////////////////////////////////

`define BOARD_KEY_W     2
`define BOARD_SW_W      8
`define BOARD_LED_W     12
`define BOARD_DIGITS    8

//////////////////////////////////////////////////////////////////////
// Default counter widths for the board clock.
//////////////////////////////////////////////////////////////////////

// Roughly a few shifts per second at board clock rates.
`define SHIFT_STROBE_W  23
// Fast enough that the eight digits look steady.
`define SCAN_STROBE_W   10
`define DEBOUNCE_W      16

`endif
